// ==== design/rom_pkg.sv ====
/*
    ROM access subsystem shared definitions
    Address and data types of the download, slot and bank paths,
    SDRAM offsets of each ROM region and the bank arbiter states
*/
`default_nettype none

package rom_pkg;

    // SDRAM side, one word is 32 bits
    typedef logic [21:0] sdram_addr_t;
    typedef logic [31:0] sdram_data_t;

    // Download side
    typedef logic [21:0] prog_addr_t;
    typedef logic [15:0] prog_data_t;
    typedef logic [24:0] ioctl_addr_t;

    // Game side, bit 0 of the main address picks a half word
    typedef logic [20:0] main_addr_t;
    typedef logic [19:0] gfx_addr_t;

    // Region offsets in SDRAM words
    localparam sdram_addr_t MAIN_BASE = 22'h000000;
    localparam sdram_addr_t GFX_BASE  = 22'h080000;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_WAIT_ACK,
        ARB_WAIT_RDY
    } arb_state_t;

endpackage

`default_nettype wire

// ==== design/rom_loader.sv ====
/*
    ROM loader
    Packs download bytes into 16-bit program words and keeps each
    word on the prog port until the SDRAM controller takes it
*/
`default_nettype none

module rom_loader import rom_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    output prog_addr_t  prog_addr,
    output prog_data_t  prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    input  logic        prog_rdy,
    output logic        dwnld_busy
);

    logic [7:0] lo_byte;
    logic       byte_wr;
    logic       word_done;

    assign byte_wr   = downloading && ioctl_wr;
    // The odd byte closes a word
    assign word_done = byte_wr && ioctl_addr[0];

    // Both byte lanes are always written
    assign prog_mask = 2'b00;

    // Busy covers the whole pending write
    assign dwnld_busy = prog_we;

    always_ff @(posedge clk) begin
        if (byte_wr && !ioctl_addr[0]) begin
            lo_byte <= ioctl_data;
        end
        if (word_done) begin
            prog_data <= {ioctl_data, lo_byte};
            prog_addr <= prog_addr_t'(ioctl_addr >> 1);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
        end else begin
            if (word_done) begin
                prog_we <= 1'b1;
            end else if (prog_we && prog_rdy) begin
                // Accepted, drop on the following edge
                prog_we <= 1'b0;
            end
        end
    end

    // Source must wait for the previous word to be taken
    assert property (@(posedge clk) disable iff (!rst_n)
        dwnld_busy |-> !ioctl_wr)
        else $error("ioctl_wr while the loader is busy");

endmodule

`default_nettype wire

// ==== design/rom_slot.sv ====
/*
    ROM request slot
    Serves cs/ok reads from a one-word cache of the last SDRAM word
    fetched. A miss raises a request to the bank arbiter and ok comes
    once the word is in the cache. DW 16 returns the half word picked
    by address bit 0, DW 32 returns the whole word.
*/
`default_nettype none

module rom_slot import rom_pkg::*; #(
    parameter int DW = 16
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        flush,
    input  logic        cs,
    input  logic [(DW == 16 ? $bits(main_addr_t) : $bits(gfx_addr_t))-1:0] addr,
    output logic [DW-1:0] data,
    output logic        ok,
    output logic        req,
    output sdram_addr_t req_addr,
    input  logic        done,
    input  sdram_data_t rdata
);

    logic [$bits(gfx_addr_t)-1:0] word;
    sdram_addr_t word_addr;
    sdram_addr_t tag;
    sdram_data_t cache_data;
    logic        valid;
    logic        hit;
    logic        fill_hit;
    logic        ok_q;
    logic [$bits(addr)-1:0] addr_q;

    generate
        if (DW == 16) begin : g_half
            assign word = addr[$bits(addr)-1:1];
            // Even address reads the low half
            assign data = addr[0] ? cache_data[31:16] : cache_data[15:0];
        end else begin : g_full
            assign word = addr;
            assign data = cache_data;
        end
    endgenerate

    assign word_addr = ((DW == 16) ? MAIN_BASE : GFX_BASE) + sdram_addr_t'(word);

    assign hit      = valid && (tag == word_addr);
    assign fill_hit = done && (req_addr == word_addr);

    // ok falls at once when cs drops or the address moves
    assign ok = ok_q && cs && (addr == addr_q);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid <= 1'b0;
            req   <= 1'b0;
            ok_q  <= 1'b0;
        end else begin
            ok_q <= cs && !flush && (hit || fill_hit);
            if (flush) begin
                valid <= 1'b0;
            end else if (done) begin
                valid <= 1'b1;
            end
            if (done) begin
                req <= 1'b0;
            end else if (cs && !hit && !req) begin
                req <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        addr_q <= addr;
        // Address follows the CPU until the request goes out
        if (!req) begin
            req_addr <= word_addr;
        end
        // Words fetched while reloading are thrown away
        if (done && !flush) begin
            tag        <= req_addr;
            cache_data <= rdata;
        end
    end

    // The arbiter answers only a pending request
    assert property (@(posedge clk) disable iff (!rst_n)
        done |-> req)
        else $error("done without a pending request");

endmodule

`default_nettype wire

// ==== design/bank_arbiter.sv ====
/*
    SDRAM bank arbiter
    Shares one read-only bank between two ROM slots in round-robin
    order, runs the rd/ack/rdy handshake and returns the word read.
    Refresh is allowed whenever the bank sits idle.
*/
`default_nettype none

module bank_arbiter import rom_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic        req0,
    input  logic        req1,
    input  sdram_addr_t addr0,
    input  sdram_addr_t addr1,
    output logic        done0,
    output logic        done1,
    output sdram_data_t rdata,
    output sdram_addr_t ba_addr,
    output logic        ba_rd,
    input  logic        ba_ack,
    input  logic        ba_rdy,
    input  sdram_data_t data_read,
    output logic        refresh_en
);

    arb_state_t state;
    logic       last;
    logic       cur;
    logic       pend0;
    logic       pend1;
    logic       pick;
    logic       finish;

    // A slot still shows req in its done cycle
    assign pend0 = req0 && !done0;
    assign pend1 = req1 && !done1;

    // Both waiting, the one not served last wins
    assign pick = (pend0 && pend1) ? ~last : pend1;

    assign finish = ((state == ARB_WAIT_ACK) && ba_ack && ba_rdy) ||
                    ((state == ARB_WAIT_RDY) && ba_rdy);

    assign refresh_en = (state == ARB_IDLE) && !pend0 && !pend1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            ba_rd <= 1'b0;
            last  <= 1'b1;      // slot 0 goes first
            cur   <= 1'b0;
            done0 <= 1'b0;
            done1 <= 1'b0;
        end else begin
            done0 <= 1'b0;
            done1 <= 1'b0;
            case (state)
                ARB_IDLE: begin
                    if (!downloading && (pend0 || pend1)) begin
                        cur   <= pick;
                        ba_rd <= 1'b1;
                        state <= ARB_WAIT_ACK;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (ba_ack) begin
                        ba_rd <= 1'b0;
                        if (!ba_rdy) begin
                            state <= ARB_WAIT_RDY;
                        end
                    end
                end
                ARB_WAIT_RDY: begin
                    // Leaving handled by finish below
                end
                default: state <= ARB_IDLE;
            endcase
            if (finish) begin
                state <= ARB_IDLE;
                last  <= cur;
                done0 <= !cur;
                done1 <= cur;
            end
        end
    end

    always_ff @(posedge clk) begin
        // Address is frozen once the read is out
        if (state == ARB_IDLE) begin
            ba_addr <= pick ? addr1 : addr0;
        end
        if (finish) begin
            rdata <= data_read;
        end
    end

    // Bank must not report data before it took the read
    assert property (@(posedge clk) disable iff (!rst_n)
        (state == ARB_WAIT_ACK) && !ba_ack |-> !ba_rdy)
        else $error("ba_rdy before ba_ack");

endmodule

`default_nettype wire

// ==== design/game_rom.sv ====
/*
    Game ROM access top level
    Download path into SDRAM plus the main CPU and graphics ROM
    slots sharing bank 0 through the arbiter
*/
`default_nettype none

module game_rom import rom_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // ROM download
    input  logic        downloading,
    input  ioctl_addr_t ioctl_addr,
    input  logic [7:0]  ioctl_data,
    input  logic        ioctl_wr,
    output logic        dwnld_busy,
    output prog_addr_t  prog_addr,
    output prog_data_t  prog_data,
    output logic [1:0]  prog_mask,
    output logic        prog_we,
    input  logic        prog_rdy,
    // Main CPU ROM
    input  logic        main_rom_cs,
    input  main_addr_t  main_rom_addr,
    output logic [15:0] main_rom_data,
    output logic        main_rom_ok,
    // Graphics ROM
    input  logic        rom0_cs,
    input  gfx_addr_t   rom0_addr,
    output logic [31:0] rom0_data,
    output logic        rom0_ok,
    // Bank 0, read only here
    output sdram_addr_t ba_addr,
    output logic        ba_rd,
    input  logic        ba_ack,
    input  logic        ba_rdy,
    input  sdram_data_t data_read,
    output logic        refresh_en
);

    logic        main_req, rom0_req;
    logic        main_done, rom0_done;
    sdram_addr_t main_req_addr, rom0_req_addr;
    sdram_data_t arb_rdata;

    rom_loader u_loader(
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .downloading( downloading   ),
        .ioctl_addr ( ioctl_addr    ),
        .ioctl_data ( ioctl_data    ),
        .ioctl_wr   ( ioctl_wr      ),
        .prog_addr  ( prog_addr     ),
        .prog_data  ( prog_data     ),
        .prog_mask  ( prog_mask     ),
        .prog_we    ( prog_we       ),
        .prog_rdy   ( prog_rdy      ),
        .dwnld_busy ( dwnld_busy    )
    );

    rom_slot #(.DW(16)) u_main_slot(
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .flush      ( downloading   ),
        .cs         ( main_rom_cs   ),
        .addr       ( main_rom_addr ),
        .data       ( main_rom_data ),
        .ok         ( main_rom_ok   ),
        .req        ( main_req      ),
        .req_addr   ( main_req_addr ),
        .done       ( main_done     ),
        .rdata      ( arb_rdata     )
    );

    rom_slot #(.DW(32)) u_rom0_slot(
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .flush      ( downloading   ),
        .cs         ( rom0_cs       ),
        .addr       ( rom0_addr     ),
        .data       ( rom0_data     ),
        .ok         ( rom0_ok       ),
        .req        ( rom0_req      ),
        .req_addr   ( rom0_req_addr ),
        .done       ( rom0_done     ),
        .rdata      ( arb_rdata     )
    );

    bank_arbiter u_arbiter(
        .clk        ( clk           ),
        .rst_n      ( rst_n         ),
        .downloading( downloading   ),
        .req0       ( main_req      ),
        .req1       ( rom0_req      ),
        .addr0      ( main_req_addr ),
        .addr1      ( rom0_req_addr ),
        .done0      ( main_done     ),
        .done1      ( rom0_done     ),
        .rdata      ( arb_rdata     ),
        .ba_addr    ( ba_addr       ),
        .ba_rd      ( ba_rd         ),
        .ba_ack     ( ba_ack        ),
        .ba_rdy     ( ba_rdy        ),
        .data_read  ( data_read     ),
        .refresh_en ( refresh_en    )
    );

endmodule

`default_nettype wire

// ==== tests/tb_clkgen.sv ====
/*
    Testbench clock and reset
    10 ns clock, active-low reset held for 16 cycles
*/
`default_nettype none

module tb_clkgen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

    always #5 clk = ~clk;

endmodule

`default_nettype wire

// ==== tests/bank_model.sv ====
/*
    SDRAM bank model
    Answers bank reads after random ack and rdy delays with data
    derived from the address, and takes program writes after a delay
*/
`default_nettype none

module bank_model import rom_pkg::*; (
    input  logic        clk,
    input  sdram_addr_t ba_addr,
    input  logic        ba_rd,
    output logic        ba_ack,
    output logic        ba_rdy,
    output sdram_data_t data_read,
    input  logic        prog_we,
    output logic        prog_rdy
);
    timeunit 1ns;
    timeprecision 100ps;

    integer      bank_seed;
    integer      prog_seed;
    int          ack_wait;
    int          rdy_wait;
    int          we_wait;
    sdram_addr_t held_addr;

    // Same rule as the testbench reference
    function automatic sdram_data_t word_at(input sdram_addr_t a);
        logic [31:0] w;
        w = {10'b0, a};
        return w * 32'h9E3779B1 + w;
    endfunction

    initial begin
        bank_seed = 97;
        prog_seed = 97;
        ba_ack    = 1'b0;
        ba_rdy    = 1'b0;
        data_read = '0;
        prog_rdy  = 1'b0;
    end

    always begin
        @(negedge clk);
        if (ba_rd) begin
            ack_wait  = $unsigned($random(bank_seed)) % 6;
            rdy_wait  = $unsigned($random(bank_seed)) % 6;
            repeat (ack_wait) @(negedge clk);
            held_addr = ba_addr;
            ba_ack    = 1'b1;
            if (rdy_wait == 0) begin
                ba_rdy    = 1'b1;
                data_read = word_at(held_addr);
            end
            @(negedge clk);
            ba_ack = 1'b0;
            ba_rdy = 1'b0;
            if (rdy_wait > 0) begin
                repeat (rdy_wait - 1) @(negedge clk);
                ba_rdy    = 1'b1;
                data_read = word_at(held_addr);
                @(negedge clk);
                ba_rdy = 1'b0;
            end
        end
    end

    always begin
        @(negedge clk);
        if (prog_we) begin
            we_wait = $unsigned($random(prog_seed)) % 6;
            repeat (we_wait) @(negedge clk);
            prog_rdy = 1'b1;
            @(negedge clk);
            prog_rdy = 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== tests/tb_game_rom.sv ====
/*
    Game ROM subsystem testbench
    Download, main and graphics reads, cache hit, flush on download
    and refresh, checked against a reference word function
*/
`default_nettype none

module tb_game_rom import rom_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 4000;

    logic        clk, rst_n;
    logic        downloading, ioctl_wr, dwnld_busy;
    ioctl_addr_t ioctl_addr;
    logic [7:0]  ioctl_data;
    prog_addr_t  prog_addr;
    prog_data_t  prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we, prog_rdy;
    logic        main_rom_cs, main_rom_ok, rom0_cs, rom0_ok;
    main_addr_t  main_rom_addr;
    gfx_addr_t   rom0_addr;
    logic [15:0] main_rom_data;
    logic [31:0] rom0_data;
    sdram_addr_t ba_addr;
    logic        ba_rd, ba_ack, ba_rdy, refresh_en;
    sdram_data_t data_read;

    integer      seed;
    int          errors, cycles, reads, writes, main_oks, gfx_oks, main_done, gfx_done;
    prog_data_t  exp_data[$];
    prog_addr_t  exp_addr[$];

    tb_clkgen u_clk(.clk(clk), .rst_n(rst_n));

    bank_model u_bank(
        .clk(clk), .ba_addr(ba_addr), .ba_rd(ba_rd), .ba_ack(ba_ack),
        .ba_rdy(ba_rdy), .data_read(data_read), .prog_we(prog_we), .prog_rdy(prog_rdy)
    );

    game_rom dut0(
        .clk(clk), .rst_n(rst_n), .downloading(downloading),
        .ioctl_addr(ioctl_addr), .ioctl_data(ioctl_data), .ioctl_wr(ioctl_wr),
        .dwnld_busy(dwnld_busy), .prog_addr(prog_addr), .prog_data(prog_data),
        .prog_mask(prog_mask), .prog_we(prog_we), .prog_rdy(prog_rdy),
        .main_rom_cs(main_rom_cs), .main_rom_addr(main_rom_addr),
        .main_rom_data(main_rom_data), .main_rom_ok(main_rom_ok),
        .rom0_cs(rom0_cs), .rom0_addr(rom0_addr), .rom0_data(rom0_data),
        .rom0_ok(rom0_ok), .ba_addr(ba_addr), .ba_rd(ba_rd), .ba_ack(ba_ack),
        .ba_rdy(ba_rdy), .data_read(data_read), .refresh_en(refresh_en)
    );

    // Expected SDRAM word, address times the golden ratio constant plus address
    function automatic sdram_data_t ref_word(input sdram_addr_t a);
        logic [31:0] w;
        w = {10'b0, a};
        return w * 32'h9E3779B1 + w;
    endfunction

    task automatic send_byte(input ioctl_addr_t a, input logic [7:0] d);
        @(negedge clk);
        ioctl_addr = a;
        ioctl_data = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        while (dwnld_busy) @(negedge clk);
    endtask

    task automatic read_main(input main_addr_t a, output int lat);
        @(negedge clk);
        main_rom_addr = a;
        main_rom_cs   = 1'b1;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!main_rom_ok);
        main_done++;
        @(negedge clk);
        main_rom_cs = 1'b0;
    endtask

    task automatic read_pair(input main_addr_t a, input gfx_addr_t g);
        logic got_main;
        logic got_gfx;
        @(negedge clk);
        main_rom_addr = a;
        rom0_addr     = g;
        main_rom_cs   = 1'b1;
        rom0_cs       = 1'b1;
        got_main = 1'b0;
        got_gfx  = 1'b0;
        while (!(got_main && got_gfx)) begin
            @(posedge clk);
            if (main_rom_ok) got_main = 1'b1;
            if (rom0_ok) got_gfx = 1'b1;
            @(negedge clk);
            if (got_main) main_rom_cs = 1'b0;
            if (got_gfx) rom0_cs = 1'b0;
        end
        main_done++;
        gfx_done++;
    endtask

    // Comparing process, sampled on the rising edge
    always @(posedge clk) begin
        sdram_data_t w;
        logic [15:0] half;
        if (rst_n) begin
            if (prog_we && prog_rdy) begin
                writes++;
                if (prog_mask !== 2'b00) begin
                    $display("error prog_mask %h expected %h", prog_mask, 2'b00);
                    errors++;
                end
                if (exp_addr.size() == 0) begin
                    $display("unexpected program write at %h", prog_addr);
                    errors++;
                end else begin
                    if (prog_addr !== exp_addr[0] || prog_data !== exp_data[0]) begin
                        $display("error prog_addr %h prog_data %h expected %h %h",
                                 prog_addr, prog_data, exp_addr[0], exp_data[0]);
                        errors++;
                    end
                    void'(exp_addr.pop_front());
                    void'(exp_data.pop_front());
                end
            end
            if (main_rom_ok) begin
                main_oks++;
                w = ref_word(MAIN_BASE + sdram_addr_t'(main_rom_addr >> 1));
                half = main_rom_addr[0] ? w[31:16] : w[15:0];
                if (main_rom_data !== half) begin
                    $display("error main_rom_data %h expected %h", main_rom_data, half);
                    errors++;
                end
            end
            if (rom0_ok) begin
                gfx_oks++;
                w = ref_word(GFX_BASE + sdram_addr_t'(rom0_addr));
                if (rom0_data !== w) begin
                    $display("error rom0_data %h expected %h", rom0_data, w);
                    errors++;
                end
            end
            if (ba_rd && ba_ack) reads++;
            if (downloading && ba_rd) begin
                $display("bank read issued while downloading");
                errors++;
            end
            if (ba_rd && refresh_en) begin
                $display("error refresh_en %h during a bank read", refresh_en);
                errors++;
            end
            if (!main_rom_cs && !rom0_cs && !ba_rd && !refresh_en) begin
                $display("error refresh_en %h with the bank idle", refresh_en);
                errors++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout, run stopped after %0d cycles", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        int lat;
        int reads_before;
        logic [7:0] lo;
        logic [7:0] b;
        main_addr_t a;
        seed = 97;
        errors = 0;
        cycles = 0;
        reads = 0;
        writes = 0;
        main_oks = 0;
        gfx_oks = 0;
        main_done = 0;
        gfx_done = 0;
        downloading = 1'b0;
        ioctl_wr = 1'b0;
        ioctl_addr = '0;
        ioctl_data = '0;
        main_rom_cs = 1'b0;
        main_rom_addr = '0;
        rom0_cs = 1'b0;
        rom0_addr = '0;
        lo = '0;
        a = '0;
        @(posedge rst_n);

        // Download of 64 bytes
        @(negedge clk);
        downloading = 1'b1;
        for (int i = 0; i < 64; i++) begin
            b = 8'($random(seed));
            if (i % 2 == 0) begin
                lo = b;
            end else begin
                exp_addr.push_back(prog_addr_t'(i / 2));
                exp_data.push_back({b, lo});
            end
            send_byte(ioctl_addr_t'(i), b);
        end
        @(negedge clk);
        downloading = 1'b0;

        // Main ROM reads at random addresses
        for (int i = 0; i < 50; i++) begin
            a = main_addr_t'($random(seed));
            read_main(a, lat);
        end

        // Other half of the last word must hit
        @(negedge clk);
        reads_before = reads;
        read_main(a ^ 21'h1, lat);
        if (lat != 2 || reads != reads_before) begin
            $display("cache hit took %0d cycles with %0d bank reads", lat,
                     reads - reads_before);
            errors++;
        end

        // Graphics and main reads together
        for (int i = 0; i < 50; i++) begin
            read_pair(main_addr_t'($random(seed)), gfx_addr_t'($random(seed)));
        end

        // Download flushes the cache and holds the read
        read_main(a, lat);
        reads_before = reads;
        @(negedge clk);
        downloading = 1'b1;
        main_rom_cs = 1'b1;
        repeat (20) begin
            @(posedge clk);
            if (main_rom_ok || ba_rd) begin
                $display("read served while downloading");
                errors++;
            end
        end
        @(negedge clk);
        downloading = 1'b0;
        do @(posedge clk); while (!main_rom_ok);
        main_done++;
        @(negedge clk);
        main_rom_cs = 1'b0;
        if (reads != reads_before + 1) begin
            $display("cache not flushed, %0d bank reads after download",
                     reads - reads_before);
            errors++;
        end

        repeat (4) @(negedge clk);
        if (writes != 32 || exp_addr.size() != 0) begin
            $display("expected 32 program writes, saw %0d", writes);
            errors++;
        end
        if (main_oks != main_done || gfx_oks != gfx_done) begin
            $display("ok count mismatch, main %0d of %0d, gfx %0d of %0d",
                     main_oks, main_done, gfx_oks, gfx_done);
            errors++;
        end
        $display("errors %0d, writes %0d, main reads %0d, gfx reads %0d, bank reads %0d",
                 errors, writes, main_oks, gfx_oks, reads);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
design/rom_pkg.sv
design/rom_loader.sv
design/rom_slot.sv
design/bank_arbiter.sv
design/game_rom.sv
tests/tb_clkgen.sv
tests/bank_model.sv
tests/tb_game_rom.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the game ROM testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_game_rom -f project.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_game_rom)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q '\*\*\* PASSED \*\*\*'; then
    exit 0
fi
exit 1
